//--- hdl/riscv_pkg.sv
package riscv_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_IMM    = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B             // LUI result
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_t;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by bit 30
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of BRANCH
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- hdl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                       clk,
    input  logic                       we,
    input  logic [4:0]                 ra1,
    input  logic [4:0]                 ra2,
    input  logic [4:0]                 wa,
    input  logic [riscv_pkg::XLEN-1:0] wd,
    output logic [riscv_pkg::XLEN-1:0] rd1,
    output logic [riscv_pkg::XLEN-1:0] rd2
);
    logic [riscv_pkg::XLEN-1:0] regs [0:31];  // Entry 0 is never written

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Asynchronous reads, x0 hardwired
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    a_x0_zero_rd1 : assert property (
        @(posedge clk) (we && wa == 5'd0) |=> (ra1 != $past(ra1) || rd1 === $past(rd1))
    );

    a_x0_zero_rd2 : assert property (
        @(posedge clk) (we && wa == 5'd0) |=> (ra2 != $past(ra2) || rd2 === $past(rd2))
    );

endmodule

//--- hdl/alu.sv
`timescale 1ns/10ps

module alu (
    input  logic [riscv_pkg::XLEN-1:0] a,
    input  logic [riscv_pkg::XLEN-1:0] b,
    input  riscv_pkg::alu_op_t         op,
    output logic [riscv_pkg::XLEN-1:0] y
);
    localparam int W = riscv_pkg::XLEN;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            riscv_pkg::ALU_ADD:    y = a + b;
            riscv_pkg::ALU_SUB:    y = a - b;
            riscv_pkg::ALU_SLL:    y = a << shamt;
            riscv_pkg::ALU_SLT:    y = {{(W-1){1'b0}}, lt_signed};
            riscv_pkg::ALU_SLTU:   y = {{(W-1){1'b0}}, lt_unsigned};
            riscv_pkg::ALU_XOR:    y = a ^ b;
            riscv_pkg::ALU_SRL:    y = a >> shamt;
            riscv_pkg::ALU_SRA:    y = $signed(a) >>> shamt;  // Sign fill
            riscv_pkg::ALU_OR:     y = a | b;
            riscv_pkg::ALU_AND:    y = a & b;
            riscv_pkg::ALU_PASS_B: y = b;
            default:               y = a + b;
        endcase
    end

endmodule

//--- hdl/control.sv
`timescale 1ns/10ps

module control (
    input  logic [31:0]                decode_inst,
    input  logic [2:0]                 execute_funct3,
    input  logic                       execute_is_branch,
    input  logic                       execute_is_jump,
    input  logic [4:0]                 execute_rs1,
    input  logic [4:0]                 execute_rs2,
    input  logic [riscv_pkg::XLEN-1:0] rs1_val,
    input  logic [riscv_pkg::XLEN-1:0] rs2_val,
    input  logic [4:0]                 wb_rd,
    input  logic                       wb_we,
    output logic [riscv_pkg::XLEN-1:0] imm,
    output riscv_pkg::alu_op_t         alu_op,
    output logic                       alu_a_pc,
    output logic                       alu_b_imm,
    output logic                       mem_we,
    output riscv_pkg::wb_sel_t         wb_sel,
    output logic                       rd_we,
    output logic                       pc_sel,
    output logic [1:0]                 fwd_rs1,   // Bit 0 decode, bit 1 execute
    output logic [1:0]                 fwd_rs2
);
    riscv_pkg::opcode_t opcode;
    riscv_pkg::alu_op_t arith_op;
    logic [2:0]  funct3;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        taken;
    logic        wb_live;

    assign opcode = riscv_pkg::opcode_t'(decode_inst[6:0]);
    assign funct3 = decode_inst[14:12];

    assign imm_i = {{20{decode_inst[31]}}, decode_inst[31:20]};
    assign imm_s = {{20{decode_inst[31]}}, decode_inst[31:25], decode_inst[11:7]};
    assign imm_b = {{19{decode_inst[31]}}, decode_inst[31], decode_inst[7],
                    decode_inst[30:25], decode_inst[11:8], 1'b0};
    assign imm_u = {decode_inst[31:12], 12'b0};
    assign imm_j = {{11{decode_inst[31]}}, decode_inst[31], decode_inst[19:12],
                    decode_inst[20], decode_inst[30:21], 1'b0};

    always_comb begin
        case (funct3)
            riscv_pkg::F3_ADD:  arith_op = (opcode == riscv_pkg::OPC_OP && decode_inst[30])
                                           ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
            riscv_pkg::F3_SLL:  arith_op = riscv_pkg::ALU_SLL;
            riscv_pkg::F3_SLT:  arith_op = riscv_pkg::ALU_SLT;
            riscv_pkg::F3_SLTU: arith_op = riscv_pkg::ALU_SLTU;
            riscv_pkg::F3_XOR:  arith_op = riscv_pkg::ALU_XOR;
            riscv_pkg::F3_SR:   arith_op = decode_inst[30] ? riscv_pkg::ALU_SRA
                                                           : riscv_pkg::ALU_SRL;
            riscv_pkg::F3_OR:   arith_op = riscv_pkg::ALU_OR;
            default:            arith_op = riscv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        imm       = imm_i;
        alu_op    = riscv_pkg::ALU_ADD;
        alu_a_pc  = 1'b0;
        alu_b_imm = 1'b0;
        mem_we    = 1'b0;
        wb_sel    = riscv_pkg::WB_ALU;
        rd_we     = 1'b0;
        case (opcode)
            riscv_pkg::OPC_LUI: begin
                imm       = imm_u;
                alu_op    = riscv_pkg::ALU_PASS_B;
                alu_b_imm = 1'b1;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_AUIPC: begin
                imm       = imm_u;
                alu_a_pc  = 1'b1;
                alu_b_imm = 1'b1;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_JAL: begin
                imm       = imm_j;
                alu_a_pc  = 1'b1;  // Target is pc + offset
                alu_b_imm = 1'b1;
                wb_sel    = riscv_pkg::WB_PC4;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_JALR: begin
                alu_b_imm = 1'b1;
                wb_sel    = riscv_pkg::WB_PC4;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_BRANCH: begin
                imm       = imm_b;
                alu_a_pc  = 1'b1;
                alu_b_imm = 1'b1;
            end
            riscv_pkg::OPC_LOAD: begin
                alu_b_imm = 1'b1;
                wb_sel    = riscv_pkg::WB_MEM;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_STORE: begin
                imm       = imm_s;
                alu_b_imm = 1'b1;
                mem_we    = 1'b1;
            end
            riscv_pkg::OPC_IMM: begin
                alu_op    = arith_op;
                alu_b_imm = 1'b1;
                rd_we     = 1'b1;
            end
            riscv_pkg::OPC_OP: begin
                alu_op = arith_op;
                rd_we  = 1'b1;
            end
            default: ;  // Unknown opcodes behave as a bubble
        endcase
    end

    // Branch decision on forwarded execute operands
    always_comb begin
        case (execute_funct3)
            riscv_pkg::F3_BEQ:  taken = rs1_val == rs2_val;
            riscv_pkg::F3_BNE:  taken = rs1_val != rs2_val;
            riscv_pkg::F3_BLT:  taken = $signed(rs1_val) < $signed(rs2_val);
            riscv_pkg::F3_BGE:  taken = $signed(rs1_val) >= $signed(rs2_val);
            riscv_pkg::F3_BLTU: taken = rs1_val < rs2_val;
            riscv_pkg::F3_BGEU: taken = rs1_val >= rs2_val;
            default:            taken = 1'b0;
        endcase
    end

    assign pc_sel = execute_is_jump || (execute_is_branch && taken);

    assign wb_live    = wb_we && (wb_rd != 5'd0);
    assign fwd_rs1[0] = wb_live && (wb_rd == decode_inst[19:15]);
    assign fwd_rs2[0] = wb_live && (wb_rd == decode_inst[24:20]);
    assign fwd_rs1[1] = wb_live && (wb_rd == execute_rs1);
    assign fwd_rs2[1] = wb_live && (wb_rd == execute_rs2);

endmodule

//--- hdl/inst_mem.sv
`timescale 1ns/10ps

module inst_mem #(
    parameter int ADDR_BITS = 10
) (
    input  logic                 clk,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic [31:0]          wdata,
    input  logic [ADDR_BITS-1:0] raddr,
    output logic [31:0]          rdata
);
    logic [31:0] mem [0:(1<<ADDR_BITS)-1];

    // Program load port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Fetch port, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- hdl/data_mem.sv
`timescale 1ns/10ps

module data_mem #(
    parameter int ADDR_BITS = 10
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  logic [31:0]                addr,
    input  logic [riscv_pkg::XLEN-1:0] wdata,
    output logic [riscv_pkg::XLEN-1:0] rdata,
    output logic                       io_valid,
    output logic [riscv_pkg::XLEN-1:0] io_data
);
    logic [riscv_pkg::XLEN-1:0] ram [0:(1<<ADDR_BITS)-1];
    logic [ADDR_BITS-1:0]       word_addr;
    logic                       is_io;
    logic                       ram_we;
    logic                       io_we;

    assign word_addr = addr[ADDR_BITS+1:2];
    assign is_io     = addr[31];         // Upper half is the output port
    assign ram_we    = we && !is_io;
    assign io_we     = we && is_io;

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[word_addr] <= wdata;
        end
        rdata <= ram[word_addr];         // Lands in writeback
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            io_valid <= 1'b0;
        end else begin
            io_valid <= io_we;
        end
    end

    always_ff @(posedge clk) begin
        if (io_we) begin
            io_data <= wdata;
        end
    end

    // An output store leaves the RAM word it addresses untouched
    a_ram_or_io : assert property (
        @(posedge clk) disable iff (rst)
            io_valid |-> ram[$past(word_addr)] === $past(ram[word_addr])
    );

endmodule

//--- hdl/riscv_core.sv
`timescale 1ns/10ps

module riscv_core #(
    parameter logic [31:0] RESET_PC       = 32'h0000_0000,
    parameter int          IMEM_ADDR_BITS = 10,
    parameter int          DMEM_ADDR_BITS = 10
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      prog_we,
    input  logic [IMEM_ADDR_BITS-1:0] prog_addr,
    input  logic [31:0]               prog_data,
    output logic                      io_valid,
    output logic [31:0]               io_data
);
    localparam int W = riscv_pkg::XLEN;

    logic [W-1:0] pc, pc_next, imem_rdata, dec_inst;
    logic         fetch_valid;

    logic [W-1:0]       imm, rf_rd1, rf_rd2, dec_rs1_val, dec_rs2_val;
    riscv_pkg::alu_op_t alu_op;
    riscv_pkg::wb_sel_t wb_sel;
    logic               alu_a_pc, alu_b_imm, mem_we, rd_we, pc_sel;
    logic [1:0]         fwd_rs1, fwd_rs2;

    logic [W-1:0]       ex_pc, ex_inst, ex_rs1, ex_rs2, ex_imm;
    riscv_pkg::alu_op_t ex_alu_op;
    riscv_pkg::wb_sel_t ex_wb_sel;
    logic               ex_alu_a_pc, ex_alu_b_imm, ex_mem_we, ex_rd_we;
    logic               ex_is_branch, ex_is_jump;
    logic [W-1:0]       ex_rs1_val, ex_rs2_val, alu_a, alu_b, alu_y;

    logic [W-1:0]       wb_pc4, wb_alu, wb_data, dmem_rdata;
    logic [4:0]         wb_rd;
    riscv_pkg::wb_sel_t wb_src;
    logic               wb_we;

    // Fetch, pc is the address of the decode instruction
    assign pc_next = pc_sel ? {alu_y[W-1:1], 1'b0} : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= RESET_PC - 32'd4;  // pc_next points at RESET_PC
            fetch_valid <= 1'b0;
        end else begin
            pc          <= pc_next;
            fetch_valid <= 1'b1;
        end
    end

    inst_mem #(.ADDR_BITS(IMEM_ADDR_BITS)) imem (
        .clk(clk), .we(prog_we && rst), .waddr(prog_addr), .wdata(prog_data),
        .raddr(pc_next[IMEM_ADDR_BITS+1:2]), .rdata(imem_rdata)
    );

    // Flushed or not yet fetched slots decode as a bubble
    assign dec_inst = (fetch_valid && !pc_sel) ? imem_rdata : riscv_pkg::NOP_INST;

    control ctrl (
        .decode_inst(dec_inst), .execute_funct3(ex_inst[14:12]),
        .execute_is_branch(ex_is_branch), .execute_is_jump(ex_is_jump),
        .execute_rs1(ex_inst[19:15]), .execute_rs2(ex_inst[24:20]),
        .rs1_val(ex_rs1_val), .rs2_val(ex_rs2_val), .wb_rd(wb_rd), .wb_we(wb_we),
        .imm(imm), .alu_op(alu_op), .alu_a_pc(alu_a_pc), .alu_b_imm(alu_b_imm),
        .mem_we(mem_we), .wb_sel(wb_sel), .rd_we(rd_we), .pc_sel(pc_sel),
        .fwd_rs1(fwd_rs1), .fwd_rs2(fwd_rs2)
    );

    reg_file rf (
        .clk(clk), .we(wb_we), .ra1(dec_inst[19:15]), .ra2(dec_inst[24:20]),
        .wa(wb_rd), .wd(wb_data), .rd1(rf_rd1), .rd2(rf_rd2)
    );

    assign dec_rs1_val = fwd_rs1[0] ? wb_data : rf_rd1;
    assign dec_rs2_val = fwd_rs2[0] ? wb_data : rf_rd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_inst   <= riscv_pkg::NOP_INST;
            ex_mem_we <= 1'b0;
            ex_rd_we  <= 1'b0;
        end else begin
            ex_inst   <= dec_inst;
            ex_mem_we <= mem_we;
            ex_rd_we  <= rd_we;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc        <= pc;
        ex_rs1       <= dec_rs1_val;
        ex_rs2       <= dec_rs2_val;
        ex_imm       <= imm;
        ex_alu_op    <= alu_op;
        ex_alu_a_pc  <= alu_a_pc;
        ex_alu_b_imm <= alu_b_imm;
        ex_wb_sel    <= wb_sel;
    end

    // Execute
    assign ex_is_branch = ex_inst[6:0] == riscv_pkg::OPC_BRANCH;
    assign ex_is_jump   = ex_inst[6:0] == riscv_pkg::OPC_JAL
                       || ex_inst[6:0] == riscv_pkg::OPC_JALR;

    assign ex_rs1_val = fwd_rs1[1] ? wb_data : ex_rs1;  // Back-to-back dependency
    assign ex_rs2_val = fwd_rs2[1] ? wb_data : ex_rs2;
    assign alu_a      = ex_alu_a_pc ? ex_pc : ex_rs1_val;
    assign alu_b      = ex_alu_b_imm ? ex_imm : ex_rs2_val;

    alu alu_i (.a(alu_a), .b(alu_b), .op(ex_alu_op), .y(alu_y));

    data_mem #(.ADDR_BITS(DMEM_ADDR_BITS)) dmem (
        .clk(clk), .rst(rst), .we(ex_mem_we), .addr(alu_y), .wdata(ex_rs2_val),
        .rdata(dmem_rdata), .io_valid(io_valid), .io_data(io_data)
    );

    // Writeback
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= ex_rd_we;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc4 <= ex_pc + 32'd4;
        wb_rd  <= ex_inst[11:7];
        wb_alu <= alu_y;
        wb_src <= ex_wb_sel;
    end

    always_comb begin
        case (wb_src)
            riscv_pkg::WB_MEM: wb_data = dmem_rdata;
            riscv_pkg::WB_PC4: wb_data = wb_pc4;
            default:           wb_data = wb_alu;
        endcase
    end

    a_no_redirect_on_nop : assert property (
        @(posedge clk) disable iff (rst) (ex_inst == riscv_pkg::NOP_INST) |-> !pc_sel
    );

endmodule

//--- verification/rv_asm.svh
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// R-type, register-register ALU group
function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input riscv_pkg::opcode_t op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input riscv_pkg::opcode_t op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input riscv_pkg::opcode_t op);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

// Byte offset, bit 0 dropped
function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_pkg::OPC_BRANCH};
endfunction

// Upper 20 bits of imm are used
function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
                                      input riscv_pkg::opcode_t op);
    return {imm[31:12], rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, riscv_pkg::OPC_JAL};
endfunction

`endif

//--- verification/riscv_core_tb.sv
`timescale 1ns/10ps

module riscv_core_tb;
    `include "rv_asm.svh"

    localparam int TIMEOUT = 2000;  // Cycles to wait for all outputs
    localparam int QUIET   = 30;    // Window that must stay silent afterwards

    logic        clk;
    logic        rst;
    logic        prog_we;
    logic [9:0]  prog_addr;
    logic [31:0] prog_data;
    logic        io_valid;
    logic [31:0] io_data;

    int          errors = 0;
    int          tests  = 0;
    logic [31:0] lfsr   = 32'hc170;
    logic [31:0] prog[$];           // Program under construction
    logic [31:0] exp_q[$];          // Expected output words
    logic [31:0] m [0:31];          // Architectural register state
    logic [31:0] dm [logic [31:0]]; // Data memory by byte address

    riscv_core #(.RESET_PC(32'h0), .IMEM_ADDR_BITS(10), .DMEM_ADDR_BITS(10)) uut (
        .clk(clk), .rst(rst), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .io_valid(io_valid), .io_data(io_data)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];  // Sign fill
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void emit(input logic [31:0] w);
        prog.push_back(w);
    endfunction

    function automatic logic [31:0] here();
        return prog.size() * 4;  // Byte address of the next word
    endfunction

    task automatic new_prog();
        prog.delete();
        exp_q.delete();
        dm.delete();
        m[0] = '0;
        emit(enc_u(32'h8000_0000, 5'd31, riscv_pkg::OPC_LUI));  // x31 is the output port
    endtask

    task automatic li(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;  // Compensates the sign of the low part
        emit(enc_u(hi, rd, riscv_pkg::OPC_LUI));
        emit(enc_i(v[11:0], rd, 3'd0, rd, riscv_pkg::OPC_IMM));
        m[rd] = v;
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, riscv_pkg::OPC_OP));
        m[rd] = alu_ref(f3, alt, m[rs1], m[rs2]);
    endtask

    task automatic op_ri(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm);
        logic [11:0] iv;
        iv = (f3 == 3'd1 || f3 == 3'd5) ? {alt ? 7'h20 : 7'h00, imm[4:0]} : imm;
        emit(enc_i(iv, rs1, f3, rd, riscv_pkg::OPC_IMM));
        m[rd] = alu_ref(f3, alt && f3 == 3'd5, m[rs1], {{20{iv[11]}}, iv});
    endtask

    task automatic sw(input logic [4:0] rs2, input logic [4:0] rs1, input logic [11:0] off);
        emit(enc_s(off, rs2, rs1, 3'b010, riscv_pkg::OPC_STORE));
        dm[m[rs1] + off] = m[rs2];
    endtask

    task automatic lw(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] off);
        emit(enc_i(off, rs1, 3'b010, rd, riscv_pkg::OPC_LOAD));
        m[rd] = dm[m[rs1] + off];
    endtask

    task automatic out(input logic [4:0] rs);
        emit(enc_s(12'd0, rs, 5'd31, 3'b010, riscv_pkg::OPC_STORE));
        exp_q.push_back(m[rs]);
    endtask

    task automatic idle_check(input string name);
        if (io_valid !== 1'b0) begin
            $display("%s: io_valid was high while the core was held in reset", name);
            errors++;
        end
    endtask

    // Load through the load port, release reset, collect and compare outputs
    task automatic run(input string name);
        logic [31:0] rx[$];
        int          cyc;
        int          errs0;
        errs0 = errors;
        tests++;
        emit(enc_j(21'd0, 5'd0));  // Halt loop
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            idle_check(name);
            prog_we   = 1'b1;
            prog_addr = i[9:0];
            prog_data = prog[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            idle_check(name);
        end
        rst = 1'b0;
        cyc = 0;
        while (rx.size() < exp_q.size() && cyc < TIMEOUT) begin
            @(negedge clk);
            if (io_valid) rx.push_back(io_data);
            cyc++;
        end
        if (rx.size() < exp_q.size()) begin
            $display("%s: timed out with %0d of %0d outputs", name, rx.size(), exp_q.size());
            errors++;
        end
        for (int i = 0; i < QUIET; i++) begin
            @(negedge clk);
            if (io_valid) rx.push_back(io_data);
        end
        if (rx.size() > exp_q.size()) begin
            $display("%s: %0d outputs more than expected", name, rx.size() - exp_q.size());
            errors++;
        end
        for (int i = 0; i < exp_q.size() && i < rx.size(); i++) begin
            if (rx[i] !== exp_q[i]) begin
                $display("Fail io_data[%0d]: expected %h, got %h", i, exp_q[i], rx[i]);
                errors++;
            end
        end
        $display("%s: %0d errors", name, errors - errs0);
    endtask

    task automatic test_alu();
        logic [31:0] pc;
        new_prog();
        li(5'd1, rand_bits(32));
        li(5'd2, rand_bits(32));
        for (int f = 0; f < 8; f++) begin
            op_rr(f[2:0], 1'b0, 5'd3, 5'd1, 5'd2);
            out(5'd3);
        end
        op_rr(3'd0, 1'b1, 5'd3, 5'd1, 5'd2);  // SUB
        out(5'd3);
        op_rr(3'd5, 1'b1, 5'd3, 5'd1, 5'd2);  // SRA
        out(5'd3);
        for (int f = 0; f < 8; f++) begin
            op_ri(f[2:0], 1'b0, 5'd4, 5'd1, rand_bits(12));
            out(5'd4);
        end
        op_ri(3'd5, 1'b1, 5'd4, 5'd1, rand_bits(12));
        out(5'd4);
        m[5] = {rand_bits(20), 12'b0};
        emit(enc_u(m[5], 5'd5, riscv_pkg::OPC_LUI));
        out(5'd5);
        pc   = here();
        m[6] = pc + {rand_bits(20), 12'b0};
        emit(enc_u(m[6] - pc, 5'd6, riscv_pkg::OPC_AUIPC));
        out(5'd6);
        run("alu");
    endtask

    task automatic test_forwarding();
        new_prog();
        li(5'd5, rand_bits(32));
        li(5'd6, rand_bits(32));
        // Each uses the previous result and the one before it
        for (int i = 0; i < 10; i++) begin
            op_rr((i % 2) ? 3'd4 : 3'd0, 1'b0, 5'(5 + (i + 2) % 3), 5'(5 + (i + 1) % 3),
                  5'(5 + i % 3));
        end
        out(5'd5);
        out(5'd6);
        out(5'd7);
        run("forwarding");
    endtask

    task automatic test_memory();
        new_prog();
        li(5'd10, 32'h100);
        for (int k = 0; k < 4; k++) begin
            li(5'(11 + k), rand_bits(32));
            sw(5'(11 + k), 5'd10, 12'(k * 4));
        end
        for (int k = 3; k >= 0; k--) begin
            lw(5'd15, 5'd10, 12'(k * 4));
            out(5'd15);
        end
        lw(5'd16, 5'd10, 12'd0);
        op_rr(3'd0, 1'b0, 5'd17, 5'd16, 5'd16);  // Load result used at once
        out(5'd17);
        run("memory");
    endtask

    task automatic branch_case(input logic [2:0] f3, input logic [31:0] a,
                               input logic [31:0] b);
        logic taken;
        li(5'd22, a);
        li(5'd23, b);
        taken = br_ref(f3, a, b);
        emit(enc_b(13'd12, 5'd23, 5'd22, f3));
        emit(enc_i({8'h0, f3, 1'b0}, 5'd0, 3'd0, 5'd24, riscv_pkg::OPC_IMM));
        emit(enc_j(21'd8, 5'd0));
        emit(enc_i({8'h0, f3, 1'b1}, 5'd0, 3'd0, 5'd24, riscv_pkg::OPC_IMM));
        m[24] = {28'h0, f3, taken};
        out(5'd24);
    endtask

    task automatic test_branches();
        logic [31:0] a;
        logic [31:0] b;
        new_prog();
        li(5'd20, 32'd5);
        li(5'd21, 32'd0);
        emit(enc_r(7'h00, 5'd20, 5'd21, 3'd0, 5'd21, riscv_pkg::OPC_OP));
        emit(enc_i(12'hfff, 5'd20, 3'd0, 5'd20, riscv_pkg::OPC_IMM));
        emit(enc_b(13'h1ff8, 5'd0, 5'd20, riscv_pkg::F3_BNE));
        m[20] = 32'd0;
        m[21] = 32'd15;  // 5 + 4 + 3 + 2 + 1
        out(5'd21);
        for (int f = 4; f < 8; f++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            if (a == b) b = a ^ 32'h1;
            branch_case(f[2:0], a, b);
            branch_case(f[2:0], b, a);
        end
        run("branches");
    endtask

    task automatic test_jumps();
        logic [31:0] pc;
        new_prog();
        m[25] = here() + 4;
        emit(enc_j(21'd12, 5'd25));
        emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd26, riscv_pkg::OPC_IMM));  // Skipped
        emit(enc_s(12'd0, 5'd26, 5'd31, 3'b010, riscv_pkg::OPC_STORE));
        out(5'd25);
        li(5'd27, here() + 16);  // Target is 20 bytes on, jalr adds 4
        pc    = here();
        m[28] = pc + 4;
        emit(enc_i(12'd4, 5'd27, 3'd0, 5'd28, riscv_pkg::OPC_JALR));
        emit(enc_i(12'h7ff, 5'd0, 3'd0, 5'd26, riscv_pkg::OPC_IMM));
        emit(enc_s(12'd0, 5'd26, 5'd31, 3'b010, riscv_pkg::OPC_STORE));
        out(5'd28);
        run("jumps");
    endtask

    task automatic test_reset();
        new_prog();
        li(5'd1, 32'h111);
        out(5'd1);
        run("reset_first");
        new_prog();
        li(5'd1, 32'h222);
        out(5'd1);
        run("reset_reload");
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        repeat (5) @(negedge clk);
        test_alu();
        test_forwarding();
        test_memory();
        test_branches();
        test_jumps();
        test_reset();
        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verification
hdl/riscv_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/control.sv
hdl/inst_mem.sv
hdl/data_mem.sv
hdl/riscv_core.sv
verification/riscv_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= riscv_core_tb
RTL_TOP    ?= riscv_core
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= All checks passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
RTL_SRC := $(shell grep '^hdl/' $(FILELIST))

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST) verification/rv_asm.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRC)

clean:
	rm -rf $(BUILD_DIR)
